// File: logic/conv1x1_pkg.sv
package conv1x1_pkg;

	//////////////////////////////
	// Sizes

	// Weight and activation width
	localparam int DATA_WIDTH = 16;

	// Input channels, one weight each
	localparam int C_IN = 4;

	// FIFO pointer and channel index width
	localparam int PTR_WIDTH = 2;

	// Full product plus two guard bits for C_IN terms
	localparam int ACC_WIDTH = 2 * DATA_WIDTH + 2;

	//////////////////////////////
	// Types

	typedef logic signed [DATA_WIDTH-1:0] data_t;
	typedef logic signed [ACC_WIDTH-1:0]  acc_t;
	typedef logic [PTR_WIDTH-1:0]         chan_t;

	// Control phases
	typedef enum logic {
		LOAD,
		RUN
	} ctrl_state_t;

endpackage

// File: logic/conv_stream_if.sv
interface conv_stream_if
	import conv1x1_pkg::*;
();

	// One-cycle sample strobe
	logic  valid;

	// Activation sample, qualified by valid
	data_t act;

	// Channel position flags
	logic  first;
	logic  last;

	// Control side drives the registered samples
	modport source (
		output valid,
		output act,
		output first,
		output last
	);

	// MAC side consumes them
	modport sink (
		input valid,
		input act,
		input first,
		input last
	);

endinterface

// File: logic/channel_counter.sv
module channel_counter
	import conv1x1_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  step,
	output chan_t count,
	output logic  first,
	output logic  last
);

	//////////////////////////////
	// Wrapping channel count

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (step) begin
			// Back to channel 0 after the last one
			if (count == chan_t'(C_IN - 1)) begin
				count <= '0;
			end else begin
				count <= count + 1'b1;
			end
		end
	end

	//////////////////////////////
	// Position flags

	// Decoded straight from the count
	assign first = (count == '0);
	assign last  = (count == chan_t'(C_IN - 1));

endmodule

// File: logic/weight_buffer.sv
module weight_buffer
	import conv1x1_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  valid_in,
	input  data_t in,
	input  logic  load_weights,
	output data_t weight
);

	//////////////////////////////
	// Input register

	logic  valid_q;
	data_t data_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= valid_in;
		end
	end

	// Payload only, qualified by valid_q
	always_ff @(posedge clk) begin
		data_q <= in;
	end

	//////////////////////////////
	// Circulating FIFO

	data_t mem [C_IN];
	chan_t rd_ptr;
	chan_t wr_ptr;
	logic  full;
	logic  write_en;

	// Once full, new weights are dropped
	assign write_en = valid_q && !full;

	// Pointers and fill state
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			full   <= 1'b0;
		end else if (load_weights) begin
			// Pop and push back, fill level unchanged
			rd_ptr <= rd_ptr + 1'b1;
			wr_ptr <= wr_ptr + 1'b1;
		end else if (write_en) begin
			wr_ptr <= wr_ptr + 1'b1;
			// Last free slot taken
			if (wr_ptr == chan_t'(C_IN - 1)) begin
				full <= 1'b1;
			end
		end
	end

	// Storage, no reset
	always_ff @(posedge clk) begin
		if (load_weights) begin
			// Head goes back in at the tail
			mem[wr_ptr] <= mem[rd_ptr];
		end else if (write_en) begin
			mem[wr_ptr] <= data_q;
		end
	end

	//////////////////////////////
	// Registered head output

	always_ff @(posedge clk) begin
		if (load_weights) begin
			weight <= mem[rd_ptr];
		end
	end

endmodule

// File: logic/conv1x1_control.sv
module conv1x1_control
	import conv1x1_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  weight_valid,
	input  logic  act_valid,
	input  data_t act_data,
	input  chan_t count,
	input  logic  first,
	input  logic  last,
	output logic  step,
	output logic  load_weights,
	output logic  weights_ready,
	conv_stream_if.source stream
);

	ctrl_state_t state;
	ctrl_state_t state_next;

	// Accepted strobes per phase
	logic weight_accept;
	logic act_accept;

	//////////////////////////////
	// Strobe qualification

	// Weights only count in LOAD
	assign weight_accept = (state == LOAD) && weight_valid;

	// Activations only count in RUN
	assign act_accept = (state == RUN) && act_valid;

	// Counter shared by both phases
	assign step = weight_accept || act_accept;

	// One FIFO pop per accepted channel
	assign load_weights = act_accept;

	//////////////////////////////
	// State machine

	always_comb begin
		state_next = state;
		case (state)
			LOAD: begin
				// Final weight moves us on
				if (weight_accept && count == chan_t'(C_IN - 1)) begin
					state_next = RUN;
				end
			end
			RUN: begin
				// Stays here until reset
				state_next = RUN;
			end
			default: begin
				state_next = LOAD;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= LOAD;
		end else begin
			state <= state_next;
		end
	end

	assign weights_ready = (state == RUN);

	//////////////////////////////
	// Activation stream register

	// Lines up with the popped weight one cycle later
	always_ff @(posedge clk) begin
		if (reset) begin
			stream.valid <= 1'b0;
		end else begin
			stream.valid <= act_accept;
		end
	end

	// Sample and flags, meaningful with valid
	always_ff @(posedge clk) begin
		if (act_accept) begin
			stream.act   <= act_data;
			stream.first <= first;
			stream.last  <= last;
		end
	end

endmodule

// File: logic/mac_unit.sv
module mac_unit
	import conv1x1_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	conv_stream_if.sink stream,
	input  data_t weight,
	output logic  result_valid,
	output acc_t  result_data
);

	//////////////////////////////
	// Multiply

	logic signed [2*DATA_WIDTH-1:0] product;
	acc_t                           product_ext;

	// Full-width signed product
	assign product = stream.act * weight;

	// Sign extended to accumulator width
	assign product_ext = acc_t'(product);

	//////////////////////////////
	// Accumulate

	acc_t acc;
	acc_t acc_next;

	// Channel 0 restarts the sum
	assign acc_next = stream.first ? product_ext : acc + product_ext;

	// Running sum, restarted by first
	always_ff @(posedge clk) begin
		if (stream.valid) begin
			acc <= acc_next;
		end
	end

	//////////////////////////////
	// Result output

	// Single-cycle pulse after the last channel
	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= stream.valid && stream.last;
		end
	end

	// Completed dot product
	always_ff @(posedge clk) begin
		if (stream.valid && stream.last) begin
			result_data <= acc_next;
		end
	end

endmodule

// File: logic/conv1x1_top.sv
module conv1x1_top
	import conv1x1_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  weight_valid,
	input  data_t weight_data,
	input  logic  act_valid,
	input  data_t act_data,
	output logic  weights_ready,
	output logic  result_valid,
	output acc_t  result_data
);

	//////////////////////////////
	// Internal wiring

	// Control to MAC samples
	conv_stream_if stream ();

	// Channel counter
	chan_t count;
	logic  first;
	logic  last;
	logic  step;

	// FIFO pop and popped weight
	logic  load_weights;
	data_t weight;

	//////////////////////////////
	// Instances

	channel_counter channel_counter_i (
		.clk   (clk),
		.reset (reset),
		.step  (step),
		.count (count),
		.first (first),
		.last  (last)
	);

	// Weights come straight from the host
	weight_buffer weight_buffer_i (
		.clk          (clk),
		.reset        (reset),
		.valid_in     (weight_valid),
		.in           (weight_data),
		.load_weights (load_weights),
		.weight       (weight)
	);

	conv1x1_control conv1x1_control_i (
		.clk           (clk),
		.reset         (reset),
		.weight_valid  (weight_valid),
		.act_valid     (act_valid),
		.act_data      (act_data),
		.count         (count),
		.first         (first),
		.last          (last),
		.step          (step),
		.load_weights  (load_weights),
		.weights_ready (weights_ready),
		.stream        (stream.source)
	);

	mac_unit mac_unit_i (
		.clk          (clk),
		.reset        (reset),
		.stream       (stream.sink),
		.weight       (weight),
		.result_valid (result_valid),
		.result_data  (result_data)
	);

endmodule

// File: verification/conv1x1_assertions.sv
module conv1x1_assertions (
	input logic clk,
	input logic reset,
	input logic act_valid,
	input logic load_weights,
	input logic weights_ready,
	input logic sample_valid,
	input logic sample_last,
	input logic result_valid
);
	timeunit 1ns;
	timeprecision 100ps;

	// FIFO pops only once all weights are in
	pop_in_run: assert property (@(posedge clk) disable iff (reset)
		load_weights |-> weights_ready)
		else $error("load_weights raised during weight loading");

	// RUN holds until the next reset
	ready_held: assert property (@(posedge clk) disable iff (reset)
		!$fell(weights_ready))
		else $error("weights_ready dropped without a reset");

	// Last weight still in the input register here
	no_act_on_rise: assert property (@(posedge clk) disable iff (reset)
		$rose(weights_ready) |-> !act_valid)
		else $error("act_valid in the cycle weights_ready rose");

	//////////////////////////////
	// MAC result timing

	result_after_last: assert property (@(posedge clk) disable iff (reset)
		sample_valid && sample_last |=> result_valid)
		else $error("no result_valid after the last channel sample");

	// No pulse without a last sample before it
	result_only_after_last: assert property (@(posedge clk) disable iff (reset)
		result_valid |-> $past(sample_valid && sample_last))
		else $error("result_valid without a preceding last sample");

endmodule

// Top level sees both the control and the MAC side
bind conv1x1_top conv1x1_assertions conv1x1_assertions_i (
	.clk           (clk),
	.reset         (reset),
	.act_valid     (act_valid),
	.load_weights  (load_weights),
	.weights_ready (weights_ready),
	.sample_valid  (stream.valid),
	.sample_last   (stream.last),
	.result_valid  (result_valid)
);

// File: verification/conv1x1_tb.sv
module conv1x1_tb
	import conv1x1_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	logic  clk = 1'b0;
	logic  reset;
	logic  weight_valid;
	data_t weight_data;
	logic  act_valid;
	data_t act_data;
	logic  weights_ready;
	logic  result_valid;
	acc_t  result_data;

	int seed;
	int errors;
	int test_errors;
	int tests_run;
	int tests_bad;

	// Weights as sent, in channel order
	data_t weights_sent [C_IN];

	// Expected and observed results, oldest first
	acc_t exp_q [$];
	acc_t got_q [$];

	always #5 clk = ~clk;

	conv1x1_top conv1x1_top_i (
		.clk           (clk),
		.reset         (reset),
		.weight_valid  (weight_valid),
		.weight_data   (weight_data),
		.act_valid     (act_valid),
		.act_data      (act_data),
		.weights_ready (weights_ready),
		.result_valid  (result_valid),
		.result_data   (result_data)
	);

	// Collect every result pulse
	always @(negedge clk) begin
		if (!reset && result_valid) begin
			got_q.push_back(result_data);
		end
	end

	//////////////////////////////
	// Checks and model

	task automatic compare_acc(input string name, input acc_t expected, input acc_t actual);
		if (expected !== actual) begin
			$display("error %s expected %0d actual %0d", name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic compare_bit(input string name, input logic expected, input logic actual);
		if (expected !== actual) begin
			$display("error %s expected %b actual %b", name, expected, actual);
			test_errors++;
		end
	endtask

	// Dot product over all channels with the loaded weights
	function automatic acc_t dot_product(input data_t a [C_IN]);
		acc_t sum;
		sum = '0;
		for (int c = 0; c < C_IN; c++) begin
			sum = sum + acc_t'(weights_sent[c]) * acc_t'(a[c]);
		end
		return sum;
	endfunction

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("%s: ok", name);
		end else begin
			tests_bad++;
			$display("%s: %0d errors", name, test_errors);
		end
		errors += test_errors;
		test_errors = 0;
		got_q.delete();
		exp_q.delete();
	endtask

	//////////////////////////////
	// Stimulus

	task automatic strobe_act(input data_t a);
		@(negedge clk);
		weight_valid = 1'b0;
		act_valid    = 1'b1;
		act_data     = a;
	endtask

	task automatic strobe_weight(input data_t w);
		@(negedge clk);
		act_valid    = 1'b0;
		weight_valid = 1'b1;
		weight_data  = w;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			act_valid    = 1'b0;
			weight_valid = 1'b0;
		end
	endtask

	task automatic random_pixel(output data_t a [C_IN]);
		for (int c = 0; c < C_IN; c++) begin
			a[c] = data_t'($random(seed));
		end
	endtask

	// Gaps of up to max_gap idle cycles after each channel
	task automatic send_pixel(input data_t a [C_IN], input int max_gap);
		exp_q.push_back(dot_product(a));
		for (int c = 0; c < C_IN; c++) begin
			strobe_act(a[c]);
			if (max_gap > 0) begin
				idle({$random(seed)} % (max_gap + 1));
			end
		end
	endtask

	// Wait for all expected results, then check count and order
	task automatic await_results(input string name);
		int cycles;
		cycles = 0;
		while (got_q.size() < exp_q.size() && cycles < 400) begin
			@(negedge clk);
			cycles++;
		end
		if (got_q.size() < exp_q.size()) begin
			$display("%s: timeout with %0d of %0d results", name, got_q.size(), exp_q.size());
			test_errors++;
		end
		// Catch stray extra pulses
		idle(4);
		if (got_q.size() != exp_q.size()) begin
			$display("%s: %0d results for %0d pixels", name, got_q.size(), exp_q.size());
			test_errors++;
		end
		while (exp_q.size() > 0 && got_q.size() > 0) begin
			compare_acc(name, exp_q.pop_front(), got_q.pop_front());
		end
	endtask

	//////////////////////////////
	// Tests

	task automatic test_reset_state;
		int cycles;
		compare_bit("reset_state", 1'b0, weights_ready);
		compare_bit("reset_state", 1'b0, result_valid);
		// Activations in LOAD must be dropped
		for (int c = 0; c < C_IN; c++) begin
			strobe_act(data_t'(c + 1));
		end
		idle(1);
		cycles = 0;
		while (!result_valid && cycles < 20) begin
			@(negedge clk);
			cycles++;
		end
		if (result_valid) begin
			$display("reset_state: result_valid pulsed before any weights were loaded");
			test_errors++;
		end
		compare_bit("reset_state", 1'b0, weights_ready);
		finish_test("reset_state");
	endtask

	task automatic test_weight_load;
		// Both extremes plus small values
		weights_sent[0] = 16'sh8000;
		weights_sent[1] = 16'sh7fff;
		weights_sent[2] = -16'sd1;
		weights_sent[3] = 16'sd1234;
		for (int c = 0; c < C_IN; c++) begin
			strobe_weight(weights_sent[c]);
			compare_bit("weight_load", 1'b0, weights_ready);
		end
		idle(1);
		compare_bit("weight_load", 1'b1, weights_ready);
		finish_test("weight_load");
	endtask

	task automatic test_single_pixel;
		data_t a [C_IN];
		acc_t  expected;
		a[0] = 16'sh8000;
		a[1] = 16'sh8000;
		a[2] = 16'sh7fff;
		a[3] = -16'sd300;
		expected = dot_product(a);
		for (int c = 0; c < C_IN; c++) begin
			strobe_act(a[c]);
		end
		// Pulse lands two cycles after the last strobe
		idle(1);
		compare_bit("single_pixel", 1'b0, result_valid);
		idle(1);
		compare_bit("single_pixel", 1'b1, result_valid);
		compare_acc("single_pixel", expected, result_data);
		idle(1);
		compare_bit("single_pixel", 1'b0, result_valid);
		finish_test("single_pixel");
	endtask

	task automatic test_back_to_back;
		data_t a [C_IN];
		for (int p = 0; p < 32; p++) begin
			random_pixel(a);
			send_pixel(a, 0);
		end
		idle(1);
		await_results("back_to_back");
		finish_test("back_to_back");
	endtask

	task automatic test_random_gaps;
		data_t a [C_IN];
		for (int p = 0; p < 16; p++) begin
			random_pixel(a);
			send_pixel(a, 3);
			idle({$random(seed)} % 4);
		end
		idle(1);
		await_results("random_gaps");
		finish_test("random_gaps");
	endtask

	task automatic test_weights_in_run;
		data_t a [C_IN];
		for (int p = 0; p < 8; p++) begin
			random_pixel(a);
			exp_q.push_back(dot_product(a));
			// New weight on every channel strobe
			for (int c = 0; c < C_IN; c++) begin
				@(negedge clk);
				act_valid    = 1'b1;
				act_data     = a[c];
				weight_valid = 1'b1;
				weight_data  = data_t'($random(seed));
			end
			strobe_weight(data_t'($random(seed)));
			idle(1);
		end
		await_results("weights_in_run");
		finish_test("weights_in_run");
	endtask

	initial begin
		seed         = 20643;
		errors       = 0;
		test_errors  = 0;
		tests_run    = 0;
		tests_bad    = 0;
		reset        = 1'b1;
		weight_valid = 1'b0;
		weight_data  = '0;
		act_valid    = 1'b0;
		act_data     = '0;
		repeat (16) @(negedge clk);
		reset = 1'b0;

		test_reset_state();
		test_weight_load();
		test_single_pixel();
		test_back_to_back();
		test_random_gaps();
		test_weights_in_run();

		$display("%0d tests run, %0d with errors, %0d errors", tests_run, tests_bad, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: all.f
logic/conv1x1_pkg.sv
logic/conv_stream_if.sv
logic/channel_counter.sv
logic/weight_buffer.sv
logic/conv1x1_control.sv
logic/mac_unit.sv
logic/conv1x1_top.sv
verification/conv1x1_assertions.sv
verification/conv1x1_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the conv1x1 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module conv1x1_tb -f all.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vconv1x1_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "all tests passed"; then
	exit 0
fi
echo "pass line missing from simulation output"
exit 1
